//--- fft_defs.svh
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// ############################################################
// stage geometry
// ############################################################

// complex samples carried by one beat
`define FFT_LANES       16

// beats in half a frame, also the delay depth
`define FFT_HALF_BEATS  16

// ############################################################
// sample widths
// ############################################################

`define FFT_IN_W        9
`define FFT_OUT_W       (`FFT_IN_W + 1)  // one bit of growth

`endif

//--- logic/fft_stage_pkg.sv
`include "fft_defs.svh"

package fft_stage_pkg;

    // ############################################################
    // sample and complex types
    // ############################################################

    typedef logic signed [`FFT_IN_W-1:0]  in_sample_t;
    typedef logic signed [`FFT_OUT_W-1:0] out_sample_t;

    typedef struct packed {
        in_sample_t re;
        in_sample_t im;
    } cplx_in_t;

    typedef struct packed {
        out_sample_t re;
        out_sample_t im;
    } cplx_out_t;

    // one beat, lane 0 in the low bits
    typedef cplx_in_t  [`FFT_LANES-1:0] beat_in_t;
    typedef cplx_out_t [`FFT_LANES-1:0] beat_out_t;

    // ############################################################
    // control types
    // ############################################################

    typedef logic [$clog2(`FFT_HALF_BEATS)-1:0] pair_idx_t;

    typedef enum logic {
        FILL = 1'b0,
        PAIR = 1'b1
    } seq_state_t;

    typedef enum logic {
        SUM  = 1'b0,
        DIFF = 1'b1
    } out_kind_t;

endpackage

//--- logic/sample_delay_line.sv
`timescale 1ns/1ps
`include "fft_defs.svh"

module sample_delay_line (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid_in,
    input  fft_stage_pkg::beat_in_t data_in,
    output fft_stage_pkg::beat_in_t delayed_beat
);

    import fft_stage_pkg::*;

    // tap 0 is the newest beat, the last tap the oldest
    beat_in_t taps [`FFT_HALF_BEATS];

    // ############################################################
    // shift chain
    // ############################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `FFT_HALF_BEATS; i++) begin
                taps[i] <= '0;
            end
        end else if (valid_in) begin
            taps[0] <= data_in;
            for (int i = 1; i < `FFT_HALF_BEATS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // beat accepted FFT_HALF_BEATS valid beats ago
    assign delayed_beat = taps[`FFT_HALF_BEATS-1];

endmodule

//--- logic/frame_sequencer.sv
`timescale 1ns/1ps
`include "fft_defs.svh"

module frame_sequencer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     valid_in,
    output logic                     pair_en,
    output fft_stage_pkg::pair_idx_t pair_idx
);

    import fft_stage_pkg::*;

    localparam pair_idx_t LAST_BEAT = pair_idx_t'(`FFT_HALF_BEATS - 1);

    seq_state_t state;
    seq_state_t state_nxt;
    pair_idx_t  beat_cnt;
    logic       half_done;

    // ############################################################
    // next state
    // ############################################################

    assign half_done = valid_in && (beat_cnt == LAST_BEAT);

    always_comb begin
        state_nxt = state;
        case (state)
            FILL: begin
                if (half_done) begin
                    state_nxt = PAIR;
                end
            end
            PAIR: begin
                if (half_done) begin
                    state_nxt = FILL;  // next frame starts filling
                end
            end
            default: state_nxt = FILL;
        endcase
    end

    // ############################################################
    // state and beat counter
    // ############################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= FILL;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (valid_in) begin
                beat_cnt <= beat_cnt + 1'b1;  // wraps at the half boundary
            end
        end
    end

    assign pair_en  = (state == PAIR);
    assign pair_idx = beat_cnt;

endmodule

//--- logic/butterfly_stage.sv
`timescale 1ns/1ps
`include "fft_defs.svh"

module butterfly_stage (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     valid_in,
    input  logic                     pair_en,
    input  fft_stage_pkg::pair_idx_t pair_idx,
    input  fft_stage_pkg::beat_in_t  first_beat,
    input  fft_stage_pkg::beat_in_t  second_beat,
    output logic                     bf_valid,
    output fft_stage_pkg::beat_out_t sum_beat,
    output fft_stage_pkg::beat_out_t diff_beat
);

    import fft_stage_pkg::*;

    localparam pair_idx_t MINUS_J_START = pair_idx_t'(`FFT_HALF_BEATS / 2);

    logic      take;
    logic      apply_minus_j;
    beat_out_t sum_comb;
    beat_out_t diff_comb;

    assign take          = valid_in && pair_en;
    assign apply_minus_j = (pair_idx >= MINUS_J_START);  // second half of the pairing

    // ############################################################
    // lane arithmetic
    // ############################################################

    always_comb begin
        out_sample_t a_re;
        out_sample_t a_im;
        out_sample_t b_re;
        out_sample_t b_im;
        out_sample_t d_re;
        out_sample_t d_im;
        for (int i = 0; i < `FFT_LANES; i++) begin
            a_re = first_beat[i].re;   // sign extended
            a_im = first_beat[i].im;
            b_re = second_beat[i].re;
            b_im = second_beat[i].im;
            d_re = a_re - b_re;
            d_im = a_im - b_im;
            sum_comb[i].re = a_re + b_re;
            sum_comb[i].im = a_im + b_im;
            if (apply_minus_j) begin
                // times -j
                diff_comb[i].re = d_im;
                diff_comb[i].im = -d_re;
            end else begin
                diff_comb[i].re = d_re;
                diff_comb[i].im = d_im;
            end
        end
    end

    // ############################################################
    // output registers
    // ############################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bf_valid <= 1'b0;
        end else begin
            bf_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sum_beat  <= sum_comb;
            diff_beat <= diff_comb;  // held until the next pair
        end
    end

endmodule

//--- logic/result_serializer.sv
`timescale 1ns/1ps
`include "fft_defs.svh"

module result_serializer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     bf_valid,
    input  fft_stage_pkg::beat_out_t sum_beat,
    input  fft_stage_pkg::beat_out_t diff_beat,
    output logic                     valid_out,
    output fft_stage_pkg::beat_out_t data_out,
    output fft_stage_pkg::out_kind_t kind_out
);

    import fft_stage_pkg::*;

    localparam pair_idx_t LAST_PTR = pair_idx_t'(`FFT_HALF_BEATS - 1);

    beat_out_t diff_buf [`FFT_HALF_BEATS];
    pair_idx_t wr_ptr;
    pair_idx_t rd_ptr;
    logic      draining;

    // ############################################################
    // difference buffer
    // ############################################################

    always_ff @(posedge clk) begin
        if (bf_valid) begin
            diff_buf[wr_ptr] <= diff_beat;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            draining <= 1'b0;
        end else begin
            if (bf_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (bf_valid && (wr_ptr == LAST_PTR)) begin
                // last difference of the frame lands this edge
                draining <= 1'b1;
                rd_ptr   <= '0;
            end else if (draining) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr == LAST_PTR) begin
                    draining <= 1'b0;
                end
            end
        end
    end

    // ############################################################
    // output stage
    // ############################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out <= 1'b0;
            kind_out  <= SUM;
        end else begin
            valid_out <= bf_valid || draining;
            kind_out  <= bf_valid ? SUM : DIFF;
        end
    end

    always_ff @(posedge clk) begin
        if (bf_valid) begin
            data_out <= sum_beat;  // sums pass straight through
        end else if (draining) begin
            data_out <= diff_buf[rd_ptr];
        end
    end

endmodule

//--- logic/fft_r2_stage_top.sv
`timescale 1ns/1ps

module fft_r2_stage_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     valid_in,
    input  fft_stage_pkg::beat_in_t  data_in,
    output logic                     valid_out,
    output fft_stage_pkg::beat_out_t data_out,
    output fft_stage_pkg::out_kind_t kind_out
);

    import fft_stage_pkg::*;

    beat_in_t  delayed_beat;
    logic      pair_en;
    pair_idx_t pair_idx;
    logic      bf_valid;
    beat_out_t sum_beat;
    beat_out_t diff_beat;

    sample_delay_line u_delay (
        .clk          (clk),
        .rstn         (rstn),
        .valid_in     (valid_in),
        .data_in      (data_in),
        .delayed_beat (delayed_beat)
    );

    frame_sequencer u_seq (
        .clk      (clk),
        .rstn     (rstn),
        .valid_in (valid_in),
        .pair_en  (pair_en),
        .pair_idx (pair_idx)
    );

    // delayed beat is the first operand
    butterfly_stage u_bf (
        .clk         (clk),
        .rstn        (rstn),
        .valid_in    (valid_in),
        .pair_en     (pair_en),
        .pair_idx    (pair_idx),
        .first_beat  (delayed_beat),
        .second_beat (data_in),
        .bf_valid    (bf_valid),
        .sum_beat    (sum_beat),
        .diff_beat   (diff_beat)
    );

    result_serializer u_ser (
        .clk       (clk),
        .rstn      (rstn),
        .bf_valid  (bf_valid),
        .sum_beat  (sum_beat),
        .diff_beat (diff_beat),
        .valid_out (valid_out),
        .data_out  (data_out),
        .kind_out  (kind_out)
    );

endmodule

//--- dv/fft_stage_props.sv
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_stage_props (
    input logic                     clk,
    input logic                     rstn,
    input logic                     valid_in,
    input logic                     pair_en,
    input logic                     valid_out,
    input fft_stage_pkg::out_kind_t kind_out
);

    logic [5:0] pair_run;  // accepted beats in the current PAIR stretch

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pair_run <= '0;
        end else if (!pair_en) begin
            pair_run <= '0;
        end else if (valid_in) begin
            pair_run <= pair_run + 6'd1;
        end
    end

    // ############################################################
    // properties
    // ############################################################

    a_quiet_in_reset: assert property (@(posedge clk) !rstn |-> !valid_out)
        else $error("valid_out high during reset");

    a_kind_known: assert property (@(posedge clk) disable iff (!rstn)
        valid_out |-> !$isunknown(kind_out))
        else $error("kind_out unknown on a valid beat");

    a_pair_run: assert property (@(posedge clk) disable iff (!rstn)
        pair_run <= 6'(`FFT_HALF_BEATS))
        else $error("pair_en held for more than a half frame of beats");

endmodule

bind fft_r2_stage_top fft_stage_props u_props (
    .clk       (clk),
    .rstn      (rstn),
    .valid_in  (valid_in),
    .pair_en   (pair_en),
    .valid_out (valid_out),
    .kind_out  (kind_out)
);

//--- dv/fft_stage_tb.sv
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_stage_tb;

    import fft_stage_pkg::*;

    localparam int HALF        = `FFT_HALF_BEATS;
    localparam int FRAME_BEATS = 2 * HALF;
    localparam int NUM_TESTS   = 5;
    localparam int SUM_LAT     = 2;  // input cycle to output cycle
    localparam int RST_CYCLES  = 4;

    localparam int PAT_RAMP    = 0;
    localparam int PAT_CONST   = 1;
    localparam int PAT_RANDOM  = 2;
    localparam int PAT_EXTREME = 3;

    typedef struct {
        string name;
        int    pattern;
        int    frames;
        int    gap;  // max idle cycles before each input beat
    } test_entry_t;

    logic      clk;
    logic      rstn;
    logic      valid_in;
    beat_in_t  data_in;
    logic      valid_out;
    beat_out_t data_out;
    out_kind_t kind_out;

    test_entry_t tests [NUM_TESTS];
    beat_in_t    frame_buf [FRAME_BEATS];

    // expected output stream, front is the next beat due
    beat_out_t exp_data [$];
    out_kind_t exp_kind [$];
    int        exp_cyc [$];

    int    cyc = 0;
    int    limit = 0;
    string cur_name;
    int    test_errs;
    int    test_checks;
    int    total_errs;
    int    total_checks;

    fft_r2_stage_top dut (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .kind_out  (kind_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ############################################################
    // cycle count and timeout
    // ############################################################

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("run timed out after %0d cycles with %0d output beats still expected",
                     cyc, exp_data.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ############################################################
    // stimulus and golden model
    // ############################################################

    function automatic in_sample_t extreme(input int sel);
        return (sel != 0) ? in_sample_t'(255) : in_sample_t'(-256);
    endfunction

    function automatic beat_in_t random_beat();
        beat_in_t r;
        for (int l = 0; l < `FFT_LANES; l++) begin
            r[l].re = in_sample_t'($urandom);
            r[l].im = in_sample_t'($urandom);
        end
        return r;
    endfunction

    task automatic fill_frame(input int pattern, input int f);
        int sh;
        for (int b = 0; b < FRAME_BEATS; b++) begin
            sh = (b < HALF) ? 0 : 1;  // fill and pair halves pick other lane bits
            for (int l = 0; l < `FFT_LANES; l++) begin
                case (pattern)
                    PAT_RAMP: begin
                        frame_buf[b][l].re = in_sample_t'(b * 16 + l + f * 5);
                        frame_buf[b][l].im = in_sample_t'(3 * b - 2 * l - f);
                    end
                    PAT_CONST: begin
                        frame_buf[b][l].re = in_sample_t'(17 * l - 120 + f);
                        frame_buf[b][l].im = in_sample_t'(30 - 5 * l);
                    end
                    PAT_EXTREME: begin
                        frame_buf[b][l].re = extreme(((l >> sh) & 1) ^ (f & 1));
                        frame_buf[b][l].im = extreme(((l >> (sh + 2)) & 1) ^ (f & 1));
                    end
                    default: begin
                        frame_buf[b][l].re = in_sample_t'($urandom);
                        frame_buf[b][l].im = in_sample_t'($urandom);
                    end
                endcase
            end
        end
    endtask

    // older beat a, newer beat b
    function automatic beat_out_t sum_of(input beat_in_t a, input beat_in_t b);
        beat_out_t r;
        int        re;
        int        im;
        for (int l = 0; l < `FFT_LANES; l++) begin
            re = int'(a[l].re) + int'(b[l].re);
            im = int'(a[l].im) + int'(b[l].im);
            r[l].re = out_sample_t'(re);
            r[l].im = out_sample_t'(im);
        end
        return r;
    endfunction

    function automatic beat_out_t diff_of(input beat_in_t a, input beat_in_t b, input int k);
        beat_out_t r;
        int        dre;
        int        dim;
        for (int l = 0; l < `FFT_LANES; l++) begin
            dre = int'(a[l].re) - int'(b[l].re);
            dim = int'(a[l].im) - int'(b[l].im);
            if (k >= HALF / 2) begin
                r[l].re = out_sample_t'(dim);  // times -j
                r[l].im = out_sample_t'(-dre);
            end else begin
                r[l].re = out_sample_t'(dre);
                r[l].im = out_sample_t'(dim);
            end
        end
        return r;
    endfunction

    task automatic drive_frame(input int gap);
        int idle;
        int k;
        for (int b = 0; b < FRAME_BEATS; b++) begin
            idle = (gap > 0) ? int'($urandom_range(gap, 0)) : 0;
            for (int i = 0; i < idle; i++) begin
                @(negedge clk);
                valid_in = 1'b0;
                data_in  = random_beat();  // junk while idle
            end
            @(negedge clk);
            valid_in = 1'b1;
            data_in  = frame_buf[b];
            if (b >= HALF) begin
                k = b - HALF;
                exp_data.push_back(sum_of(frame_buf[k], frame_buf[b]));
                exp_kind.push_back(SUM);
                exp_cyc.push_back(cyc + SUM_LAT);
                if (k == HALF - 1) begin
                    // drain follows the last sum directly
                    for (int j = 0; j < HALF; j++) begin
                        exp_data.push_back(diff_of(frame_buf[j], frame_buf[j + HALF], j));
                        exp_kind.push_back(DIFF);
                        exp_cyc.push_back(cyc + SUM_LAT + 1 + j);
                    end
                end
            end
        end
    endtask

    // ############################################################
    // output monitor
    // ############################################################

    task automatic record_error();
        test_errs++;
        total_errs++;
    endtask

    always @(negedge clk) begin
        beat_out_t e_data;
        out_kind_t e_kind;
        int        e_cyc;
        if (rstn && valid_out) begin
            if (exp_data.size() == 0) begin
                $display("test %s: unexpected output beat at cycle %0d", cur_name, cyc);
                record_error();
            end else begin
                e_data = exp_data.pop_front();
                e_kind = exp_kind.pop_front();
                e_cyc  = exp_cyc.pop_front();
                test_checks++;
                total_checks++;
                if (kind_out !== e_kind) begin
                    $display("MISMATCH %s kind at cycle %0d: expected %s actual %s",
                             cur_name, cyc, e_kind.name(), kind_out.name());
                    record_error();
                end
                if (data_out !== e_data) begin
                    $display("MISMATCH %s data at cycle %0d: expected %h actual %h",
                             cur_name, cyc, e_data, data_out);
                    record_error();
                end
                if (cyc != e_cyc) begin
                    $display("test %s: output beat came at cycle %0d but was due at %0d",
                             cur_name, cyc, e_cyc);
                    record_error();
                end
            end
        end
    end

    // ############################################################
    // test sequence
    // ############################################################

    task automatic run_test(input test_entry_t te);
        cur_name    = te.name;
        test_errs   = 0;
        test_checks = 0;
        for (int f = 0; f < te.frames; f++) begin
            fill_frame(te.pattern, f);
            drive_frame(te.gap);
        end
        @(negedge clk);
        valid_in = 1'b0;
        data_in  = '0;
        while (exp_data.size() > 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);  // output has to stay quiet here
        $display("test %-14s frames=%0d beats=%0d errors=%0d %s", te.name, te.frames,
                 test_checks, test_errs, (test_errs == 0) ? "ok" : "failed");
    endtask

    initial begin
        rstn     = 1'b0;
        valid_in = 1'b0;
        data_in  = '0;
        void'($urandom(32'h0e57_a047));
        total_errs   = 0;
        total_checks = 0;
        cur_name     = "reset";

        tests[0] = '{"ramp_no_gaps", PAT_RAMP, 2, 0};
        tests[1] = '{"constant", PAT_CONST, 1, 0};
        tests[2] = '{"extremes", PAT_EXTREME, 2, 0};
        tests[3] = '{"random_gaps", PAT_RANDOM, 4, 3};
        tests[4] = '{"back_to_back", PAT_RANDOM, 3, 0};

        // worst case beats and gaps, plus room for latency and drain
        limit = RST_CYCLES + 10;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += tests[t].frames * (FRAME_BEATS * (tests[t].gap + 1) + 40);
        end

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(tests[t]);
        end

        $display("tests=%0d beats_checked=%0d errors=%0d", NUM_TESTS, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
logic/fft_stage_pkg.sv
logic/sample_delay_line.sv
logic/frame_sequencer.sv
logic/butterfly_stage.sv
logic/result_serializer.sv
logic/fft_r2_stage_top.sv
dv/fft_stage_props.sv
dv/fft_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fft_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := fft_defs.svh $(wildcard logic/*.sv) $(wildcard dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
